//--- files.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/rx_buffer.sv
logic/code_sequencer.sv
logic/uart_link_top.sv
tests/uart_link_assertions.sv
tests/uart_link_checker.sv
tests/uart_link_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module uart_link_tb

out=$(./obj_dir/Vuart_link_tb)
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1

//--- tests/uart_link_tb.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_link_tb;
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int NBITS = `UART_FRAME_BITS;
    localparam int N_ENTRIES = 8;

    // one serial frame on rx, gap of zero picks a random gap.
    typedef struct packed {
        logic [7:0] data;
        logic       corrupt;
        logic [3:0] gap;
        logic [2:0] credits;
    } stim_t;

    logic         clk;
    logic         rst;
    logic         rx;
    logic         credit_return;
    logic         tx;
    rx_item_t     out_item;
    logic         out_valid;
    link_status_t status;
    logic         exp_push;
    rx_item_t     exp_item;
    int           check_errors;
    int           delivered;
    int           frames;

    stim_t table_q [N_ENTRIES];
    int    gaps [N_ENTRIES];
    int    seed;
    int    cycles;
    int    cycle_limit;
    int    run_errors;

    uart_link_top uut (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .credit_return (credit_return),
        .tx            (tx),
        .out_item      (out_item),
        .out_valid     (out_valid),
        .status        (status)
    );

    uart_link_checker chk (
        .clk           (clk),
        .rst           (rst),
        .tx            (tx),
        .out_item      (out_item),
        .out_valid     (out_valid),
        .status        (status),
        .credit_return (credit_return),
        .exp_push      (exp_push),
        .exp_item      (exp_item),
        .errors        (check_errors),
        .delivered     (delivered),
        .frames        (frames)
    );

    bind uart_link_top uart_link_assertions sva (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ----------------------------------------
    // run limit
    // ----------------------------------------

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // one frame on rx, bit 0 first, each bit held for CPB cycles.
    task automatic send_frame(input logic [7:0] data, input logic corrupt, input int gap);
        logic [NBITS-1:0] bits;
        bits = '1;
        bits[0] = 1'b0;
        bits[8:1] = data;
        if (`UART_PARITY != 0) begin
            bits[9] = (^data) ^ corrupt;
        end
        rx = 1'b1;
        repeat (gap * CPB) @(negedge clk);
        exp_item.data = data;
        exp_item.parity_error = (`UART_PARITY != 0) && corrupt;
        exp_push = 1'b1;
        for (int b = 0; b < NBITS; b++) begin
            rx = bits[b];
            @(negedge clk);
            exp_push = 1'b0;
            repeat (CPB - 1) @(negedge clk);
        end
        rx = 1'b1;
    endtask

    task automatic grant_credits(input int n);
        for (int i = 0; i < n; i++) begin
            credit_return = 1'b1;
            @(negedge clk);
            credit_return = 1'b0;
            @(negedge clk);
        end
    endtask

    initial begin
        rst = 1'b1;
        rx = 1'b1;
        credit_return = 1'b0;
        exp_push = 1'b0;
        exp_item = '0;
        cycles = 0;
        run_errors = 0;
        seed = 32'h5b4d;

        // at most RX_BUF_DEPTH frames between credit grants.
        table_q[0] = '{8'h41, 1'b0, 4'd2, 3'd0};
        table_q[1] = '{8'h00, 1'b0, 4'd0, 3'd0};
        table_q[2] = '{8'hff, 1'b1, 4'd1, 3'd0};
        table_q[3] = '{8'h5a, 1'b0, 4'd3, 3'd4};
        table_q[4] = '{8'h3c, 1'b0, 4'd0, 3'd1};
        table_q[5] = '{8'h81, 1'b1, 4'd2, 3'd1};
        table_q[6] = '{8'h7e, 1'b0, 4'd0, 3'd1};
        table_q[7] = '{8'h12, 1'b0, 4'd1, 3'd1};

        cycle_limit = 16 + `SEQ_START_DELAY;
        for (int i = 0; i < N_ENTRIES; i++) begin
            gaps[i] = (table_q[i].gap != 0) ? int'(table_q[i].gap)
                                            : 1 + ($unsigned($random(seed)) % 4);
            cycle_limit += (gaps[i] + NBITS) * CPB + 2 * int'(table_q[i].credits);
        end
        cycle_limit = 2 * cycle_limit;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_ENTRIES; i++) begin
            send_frame(table_q[i].data, table_q[i].corrupt, gaps[i]);
            grant_credits(int'(table_q[i].credits));
        end

        while (delivered < N_ENTRIES) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (frames == 0) begin
            $display("no frame was decoded on tx");
            run_errors++;
        end
        if (delivered != N_ENTRIES) begin
            $display("more items delivered than were sent");
            run_errors++;
        end

        $display("errors: checker %0d, run %0d", check_errors, run_errors);
        if (check_errors == 0 && run_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/uart_link_checker.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_link_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tx,
    input  uart_pkg::rx_item_t     out_item,
    input  logic                   out_valid,
    input  uart_pkg::link_status_t status,
    input  logic                   credit_return,
    input  logic                   exp_push,
    input  uart_pkg::rx_item_t     exp_item,
    output int                     errors,
    output int                     delivered,
    output int                     frames
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int NBITS = `UART_FRAME_BITS;

    rx_item_t   exp_q [$];
    rx_item_t   exp;
    int         cyc;
    int         credits_seen;
    int         tick;
    int         bit_no;
    bit         started;
    bit         in_frame;
    bit         seen_prev;
    bit         corrupt_sent;
    logic [7:0] data;

    task automatic mismatch(input string name, input int expected, input int actual);
        $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        errors++;
    endtask

    // ----------------------------------------
    // checks at the rising clock edge
    // ----------------------------------------

    always @(posedge clk) begin
        if (rst) begin
            cyc = 0;
            started = 0;
            in_frame = 0;
            seen_prev = 0;
            corrupt_sent = 0;
            credits_seen = 0;
            errors = 0;
            delivered = 0;
            frames = 0;
        end else begin
            if (exp_push) begin
                exp_q.push_back(exp_item);
                if (exp_item.parity_error) begin
                    corrupt_sent = 1;
                end
            end
            if (credit_return) begin
                credits_seen++;
            end

            // running stays high once the first frame has started.
            if (started && !status.running) begin
                mismatch("status.running", 1, 0);
            end

            // start-up and transmit frame decode.
            if (!started) begin
                if (!tx) begin
                    started = 1;
                    in_frame = 1;
                    tick = 0;
                    if (cyc != `SEQ_START_DELAY) begin
                        mismatch("first start bit cycle", `SEQ_START_DELAY, cyc);
                    end
                    if (!status.running) begin
                        mismatch("status.running", 1, 0);
                    end
                end else if (status.running) begin
                    mismatch("status.running", 0, 1);
                end
            end else if (!in_frame) begin
                if (!tx) begin
                    in_frame = 1;
                    tick = 0;
                end
            end else begin
                tick++;
            end

            if (in_frame && (tick % CPB) == CPB / 2) begin
                bit_no = tick / CPB;
                if (bit_no == 0 && tx !== 1'b0) begin
                    mismatch("tx start bit", 0, tx);
                end else if (bit_no >= 1 && bit_no <= 8) begin
                    data[bit_no - 1] = tx;
                end else if (bit_no == 9 && NBITS == 11) begin
                    if (tx !== ^data) begin
                        mismatch("tx parity bit", ^data, tx);
                    end
                end
                if (bit_no == NBITS - 1) begin
                    if (tx !== 1'b1) begin
                        mismatch("tx stop bit", 1, tx);
                    end
                    if (data !== 8'(frames % 64)) begin
                        mismatch("tx data", frames % 64, data);
                    end
                    frames++;
                    in_frame = 0;
                end
            end

            // delivered items against the expected order.
            if (out_valid) begin
                delivered++;
                if (delivered > credits_seen) begin
                    $display("out_valid at %0t without a returned credit", $time);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("item delivered at %0t with none expected", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (out_item.data !== exp.data) begin
                        mismatch("out_item.data", exp.data, out_item.data);
                    end
                    if (out_item.parity_error !== exp.parity_error) begin
                        mismatch("out_item.parity_error", exp.parity_error,
                                 out_item.parity_error);
                    end
                    if (exp.parity_error && !status.parity_seen) begin
                        mismatch("status.parity_seen", 1, 0);
                    end
                end
            end

            // parity_seen rises only after a corrupted frame.
            if (status.parity_seen && !corrupt_sent) begin
                mismatch("status.parity_seen", 0, 1);
            end

            // parity_seen is sticky.
            if (seen_prev && !status.parity_seen) begin
                mismatch("status.parity_seen", 1, 0);
            end
            seen_prev = status.parity_seen;
            cyc++;
        end
    end

endmodule

//--- tests/uart_link_assertions.sv
`timescale 1ns/10ps

module uart_link_assertions (
    input logic              clk,
    input logic              rst,
    input logic              tx,
    input logic              out_valid,
    input logic              credit_return,
    input uart_pkg::tx_req_t tx_req,
    input logic              tx_credit
);
    import uart_pkg::*;

    logic outstanding;
    int   credits_open;

    // a frame is in flight between request and credit.
    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (tx_req.valid) begin
            outstanding <= 1'b1;
        end else if (tx_credit) begin
            outstanding <= 1'b0;
        end
    end

    // credits granted by the consumer and not yet used.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits_open <= 0;
        end else begin
            credits_open <= credits_open + int'(credit_return) - int'(out_valid);
        end
    end

    a_credit_out: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (credits_open > 0))
        else $error("out_valid without an outstanding credit");

    a_reset_idle: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (tx && !out_valid))
        else $error("tx or out_valid active during reset");

    a_one_frame: assert property (@(posedge clk) disable iff (rst)
        tx_req.valid |-> !outstanding)
        else $error("second transmit request before tx_credit");

endmodule

//--- logic/uart_link_top.sv
`timescale 1ns/10ps

module uart_link_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rx,
    input  logic                   credit_return,
    output logic                   tx,
    output uart_pkg::rx_item_t     out_item,
    output logic                   out_valid,
    output uart_pkg::link_status_t status
);
    import uart_pkg::*;

    tx_req_t  tx_req;
    logic     tx_credit;
    rx_item_t rx_item;
    logic     rx_item_valid;

    // ----------------------------------------
    // transmit side
    // ----------------------------------------

    code_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .tx_credit     (tx_credit),
        .rx_item_valid (rx_item_valid),
        .rx_item       (rx_item),
        .tx_req        (tx_req),
        .status        (status)
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst       (rst),
        .tx_req    (tx_req),
        .tx        (tx),
        .tx_credit (tx_credit)
    );

    // ----------------------------------------
    // receive side
    // ----------------------------------------

    uart_rx u_rx (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_item       (rx_item),
        .rx_item_valid (rx_item_valid)
    );

    rx_buffer u_buffer (
        .clk           (clk),
        .rst           (rst),
        .in_item       (rx_item),
        .in_valid      (rx_item_valid),
        .credit_return (credit_return),
        .out_item      (out_item),
        .out_valid     (out_valid)
    );

endmodule

//--- logic/code_sequencer.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module code_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tx_credit,
    input  logic                   rx_item_valid,
    input  uart_pkg::rx_item_t     rx_item,
    output uart_pkg::tx_req_t      tx_req,
    output uart_pkg::link_status_t status
);
    import uart_pkg::*;

    // request goes out two cycles ahead of its start bit.
    localparam int LAUNCH_AT = `SEQ_START_DELAY - 2;
    localparam int DELAY_W = $clog2(`SEQ_START_DELAY);

    logic [DELAY_W-1:0] delay_cnt;
    logic               delay_done;
    logic               credit;
    logic               issue;
    logic [5:0]         code;

    assign delay_done = (delay_cnt == DELAY_W'(LAUNCH_AT));
    // a returning credit can be spent in the same cycle.
    assign issue = delay_done && (credit || tx_credit);

    // ----------------------------------------
    // start-up delay
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            delay_cnt <= '0;
        end else if (!delay_done) begin
            delay_cnt <= delay_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // code issue against the transmit credit
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            credit       <= 1'b1;
            code         <= '0;
            tx_req.valid <= 1'b0;
        end else begin
            tx_req.valid <= issue;
            if (issue) begin
                credit      <= 1'b0;
                code        <= code + 1'b1;
                tx_req.data <= {2'b00, code};
            end else if (tx_credit) begin
                credit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            // running rises with the first start bit.
            if (tx_req.valid) begin
                status.running <= 1'b1;
            end
            if (rx_item_valid && rx_item.parity_error) begin
                status.parity_seen <= 1'b1;
            end
        end
    end

endmodule

//--- logic/rx_buffer.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module rx_buffer (
    input  logic               clk,
    input  logic               rst,
    input  uart_pkg::rx_item_t in_item,
    input  logic               in_valid,
    input  logic               credit_return,
    output uart_pkg::rx_item_t out_item,
    output logic               out_valid
);
    import uart_pkg::*;

    localparam int DEPTH = `RX_BUF_DEPTH;
    localparam int AW = $clog2(DEPTH);

    rx_item_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   credits;
    logic          full;
    logic          push;
    logic          pop;
    logic          credit_take;

    assign full = (count == (AW + 1)'(DEPTH));
    // a write while full is dropped, the receiver has no back-pressure.
    assign push = in_valid && !full;
    // an entry leaves only against a credit.
    assign pop = (count != '0) && (credits != '0);
    // credits saturate at the buffer depth.
    assign credit_take = credit_return && ((credits != (AW + 1)'(DEPTH)) || pop);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
        if (pop) begin
            out_item <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({credit_take, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    output uart_pkg::rx_item_t rx_item,
    output logic               rx_item_valid
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int BAUD_W = $clog2(CPB);
    localparam bit PARITY_EN = (`UART_PARITY != 0);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_DATA   = 3'd2;
    localparam logic [2:0] S_PARITY = 3'd3;
    localparam logic [2:0] S_STOP   = 3'd4;

    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    logic [2:0]        state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_idx;
    uart_byte_t        shreg;
    logic              par_bit;
    logic              bit_end;

    // ----------------------------------------
    // input synchronizer and edge detect
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // mid-bit point of every bit after the start bit.
    assign bit_end = (baud_cnt == BAUD_W'(CPB - 1));

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            baud_cnt      <= '0;
            bit_idx       <= '0;
            rx_item_valid <= 1'b0;
        end else begin
            rx_item_valid <= 1'b0;
            baud_cnt      <= baud_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    baud_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (baud_cnt == BAUD_W'(HALF - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // high again at mid-bit means a glitch.
                        state    <= rx_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        shreg    <= {rx_sync, shreg[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= PARITY_EN ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        par_bit  <= rx_sync;
                        state    <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        state                <= S_IDLE;
                        rx_item_valid        <= 1'b1;
                        rx_item.data         <= shreg;
                        rx_item.parity_error <= PARITY_EN && (par_bit != ^shreg);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart_tx (
    input  logic              clk,
    input  logic              rst,
    input  uart_pkg::tx_req_t tx_req,
    output logic              tx,
    output logic              tx_credit
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int NBITS = `UART_FRAME_BITS;
    localparam int BAUD_W = $clog2(CPB);
    localparam int BIT_W = $clog2(NBITS);
    localparam bit PARITY_EN = (`UART_PARITY != 0);

    logic              busy;
    logic [BAUD_W-1:0] baud_cnt;
    logic [BIT_W-1:0]  bit_idx;
    logic [NBITS-1:0]  frame;
    logic [NBITS-2:0]  shreg;

    // frame as sent, bit 0 first.
    always_comb begin
        frame = '1;
        frame[0] = 1'b0;
        frame[8:1] = tx_req.data;
        if (PARITY_EN) begin
            frame[9] = ^tx_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            tx        <= 1'b1;
            tx_credit <= 1'b0;
            baud_cnt  <= '0;
            bit_idx   <= '0;
        end else begin
            tx_credit <= 1'b0;
            if (!busy) begin
                // a request only arrives while idle.
                if (tx_req.valid) begin
                    busy     <= 1'b1;
                    tx       <= frame[0];
                    shreg    <= frame[NBITS-1:1];
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                end
            end else if (baud_cnt == BAUD_W'(CPB - 1)) begin
                baud_cnt <= '0;
                if (bit_idx == BIT_W'(NBITS - 1)) begin
                    // stop bit done, hand the slot back.
                    busy      <= 1'b0;
                    tx        <= 1'b1;
                    tx_credit <= 1'b1;
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                    tx      <= shreg[0];
                    shreg   <= {1'b1, shreg[NBITS-2:1]};
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/uart_pkg.sv
package uart_pkg;

    // one serial data word.
    typedef logic [7:0] uart_byte_t;

    // ----------------------------------------
    // sequencer to transmitter
    // ----------------------------------------

    // single cycle request, only while a credit is held.
    typedef struct packed {
        logic       valid;
        uart_byte_t data;
    } tx_req_t;

    // ----------------------------------------
    // receiver to buffer to consumer
    // ----------------------------------------

    typedef struct packed {
        uart_byte_t data;
        logic       parity_error;
    } rx_item_t;

    // status lines, both active high.
    typedef struct packed {
        logic running;
        logic parity_seen;
    } link_status_t;

endpackage

//--- logic/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// ----------------------------------------
// serial line timing
// ----------------------------------------

// clock cycles per serial bit, 8 for simulation.
// the board runs 48 MHz at 1 Mbaud, which needs 48.
`define UART_CLKS_PER_BIT 8

// 1 adds an even parity bit after the data bits.
`define UART_PARITY 1

// start bit, eight data bits, optional parity, stop bit.
`define UART_FRAME_BITS (10 + `UART_PARITY)

// ----------------------------------------
// link control
// ----------------------------------------

// cycles from reset release to the first start bit.
`define SEQ_START_DELAY 20

// receive buffer entries, a power of two.
`define RX_BUF_DEPTH 4

`endif
